/* design/acw_params.svh */
// region count, register-port base address and register word offsets shared by all RTL
`ifndef ACW_PARAMS_SVH
`define ACW_PARAMS_SVH

// protection table size, four 8-bit region bytes per configuration word
`define ACW_NUM_REGIONS 8
`define ACW_NUM_CFG_WORDS 2
`define ACW_REGIONS_PER_WORD (`ACW_NUM_REGIONS / `ACW_NUM_CFG_WORDS)

// register port decodes address bits 31:10 against this value
`define ACW_BASE_ADDR 22'h0

// word offsets, taken from address bits 9:2
`define ACW_OFS_GO_IDLE 0
`define ACW_OFS_DENIED_ADDR 1
`define ACW_OFS_DENIED_TYPE 2
`define ACW_OFS_STATE 3
`define ACW_OFS_INTR_STATE 4
`define ACW_OFS_INTR_ENABLE 5
`define ACW_OFS_INTR_TEST 6

// configuration words first, then one address word per region
`define ACW_OFS_REGIONS 7

`endif

/* design/acw_bus_pkg.sv */
// reduced TileLink-UL channel types shared by the host, device and CPU ports
package acw_bus_pkg;

	// A channel opcodes, other encodings are refused by the gate
	typedef enum logic [2:0] {
		PutFullData    = 3'h0,
		PutPartialData = 3'h1,
		Get            = 3'h4
	} tl_opcode_a_e;

	// D channel opcodes
	typedef enum logic [2:0] {
		AccessAck     = 3'h0,
		AccessAckData = 3'h1
	} tl_opcode_d_e;

	// host to device, A request plus D ready
	typedef struct packed {
		logic         a_valid;
		tl_opcode_a_e a_opcode;
		logic [31:0]  a_address;
		logic [31:0]  a_data;
		logic [7:0]   a_source;
		logic [1:0]   a_size;
		logic [3:0]   a_mask;
		logic         d_ready;
	} tl_h2d_t;

	// device to host, D response plus A ready
	typedef struct packed {
		logic         d_valid;
		tl_opcode_d_e d_opcode;
		logic [31:0]  d_data;
		logic [7:0]   d_source;
		logic         d_error;
		logic         a_ready;
	} tl_d2h_t;

endpackage

/* design/acw_prot_pkg.sv */
// region configuration, denial record and gate state types of the protection logic
`include "acw_params.svh"

package acw_prot_pkg;

	// matching mode, only off and top-of-range are decoded
	typedef enum logic [1:0] {
		MODE_OFF = 2'd0,
		MODE_TOR = 2'd1
	} region_mode_e;

	// one region byte, bit 2 and bits 7:5 are kept but unused
	typedef struct packed {
		logic [2:0]   rsvd;
		region_mode_e mode;
		logic         x;
		logic         w;
		logic         r;
	} region_cfg_t;

	// CPU sees a raw word, the checker sees four region bytes
	typedef union packed {
		logic [31:0] raw;
		region_cfg_t [`ACW_REGIONS_PER_WORD-1:0] region;
	} cfg_word_u;

	// address and opcode of the last refused host request
	typedef struct packed {
		logic [31:0] addr;
		logic [2:0]  opcode;
	} deny_rec_t;

	typedef enum logic [1:0] {
		IDLE        = 2'd0,
		BLOCK_START = 2'd1,
		BLOCK_IDLE  = 2'd2,
		BLOCK_ERR   = 2'd3
	} gate_state_e;

endpackage

/* design/acw_region_regs.sv */
// region table storage, written and read back one word at a time from the register port
`include "acw_params.svh"

module acw_region_regs (
	input  logic clk,
	input  logic rst,
	input  logic wr_en_i,
	input  logic [3:0] wr_idx_i,
	input  logic [31:0] wr_data_i,
	input  logic [3:0] rd_idx_i,
	output logic [31:0] rd_data_o,
	output acw_prot_pkg::cfg_word_u [`ACW_NUM_CFG_WORDS-1:0] cfg_o,
	output logic [`ACW_NUM_REGIONS-1:0][29:0] addr_o
);
	import acw_prot_pkg::*;

	cfg_word_u [`ACW_NUM_CFG_WORDS-1:0] cfg_q;
	// address words hold address bits 31:2 in their low 30 bits
	logic [`ACW_NUM_REGIONS-1:0][29:0] addr_q;

	// index 0..1 are config words, 2..9 the address words
	always_ff @(posedge clk, negedge rst) begin
		if (!rst) begin
			cfg_q <= '0;
			addr_q <= '0;
		end else if (wr_en_i) begin
			for (int i = 0; i < `ACW_NUM_CFG_WORDS; i++) begin
				if (wr_idx_i == 4'(i))
					cfg_q[i].raw <= wr_data_i;
			end
			for (int i = 0; i < `ACW_NUM_REGIONS; i++) begin
				if (wr_idx_i == 4'(i + `ACW_NUM_CFG_WORDS))
					addr_q[i] <= wr_data_i[29:0];
			end
		end
	end

	// readback mux, unused indices read zero
	always_comb begin
		rd_data_o = '0;
		for (int i = 0; i < `ACW_NUM_CFG_WORDS; i++) begin
			if (rd_idx_i == 4'(i))
				rd_data_o = cfg_q[i].raw;
		end
		for (int i = 0; i < `ACW_NUM_REGIONS; i++) begin
			if (rd_idx_i == 4'(i + `ACW_NUM_CFG_WORDS))
				rd_data_o = {2'b00, addr_q[i]};
		end
	end

	assign cfg_o = cfg_q;
	assign addr_o = addr_q;

endmodule

/* design/acw_region_check.sv */
// top-of-range region match and read/write permission check for the current host request
`include "acw_params.svh"

module acw_region_check (
	input  acw_prot_pkg::cfg_word_u [`ACW_NUM_CFG_WORDS-1:0] cfg_i,
	input  logic [`ACW_NUM_REGIONS-1:0][29:0] addr_i,
	input  logic [31:0] req_addr_i,
	input  acw_bus_pkg::tl_opcode_a_e req_opcode_i,
	output logic allow_o
);
	import acw_bus_pkg::*;
	import acw_prot_pkg::*;

	region_cfg_t [`ACW_NUM_REGIONS-1:0] region;
	// lower bound of region i is the address word of region i-1
	logic [`ACW_NUM_REGIONS-1:0][29:0] lower;
	logic [`ACW_NUM_REGIONS-1:0] match;
	region_cfg_t sel;
	logic hit;

	// split each config word into its region bytes
	always_comb begin
		for (int w = 0; w < `ACW_NUM_CFG_WORDS; w++) begin
			for (int b = 0; b < `ACW_REGIONS_PER_WORD; b++)
				region[w * `ACW_REGIONS_PER_WORD + b] = cfg_i[w].region[b];
		end
	end

	assign lower = {addr_i[`ACW_NUM_REGIONS-2:0], 30'b0};

	always_comb begin
		for (int i = 0; i < `ACW_NUM_REGIONS; i++) begin
			match[i] = (region[i].mode == MODE_TOR) && (req_addr_i[31:2] >= lower[i]) &&
				(req_addr_i[31:2] < addr_i[i]);
		end
	end

	// walk downward so the lowest matching region wins
	always_comb begin
		sel = '0;
		hit = 1'b0;
		for (int i = `ACW_NUM_REGIONS - 1; i >= 0; i--) begin
			if (match[i]) begin
				sel = region[i];
				hit = 1'b1;
			end
		end
		case (req_opcode_i)
			Get: allow_o = hit && sel.r;
			PutFullData, PutPartialData: allow_o = hit && sel.w;
			// unknown opcodes are never allowed
			default: allow_o = 1'b0;
		endcase
	end

endmodule

/* design/acw_host_gate.sv */
// blocking FSM between host and device, forwards allowed traffic and answers denials with an error
module acw_host_gate (
	input  logic clk,
	input  logic rst,
	input  acw_bus_pkg::tl_h2d_t host_req_i,
	output acw_bus_pkg::tl_d2h_t host_rsp_o,
	output acw_bus_pkg::tl_h2d_t dev_req_o,
	input  acw_bus_pkg::tl_d2h_t dev_rsp_i,
	input  logic allow_i,
	input  logic go_idle_i,
	output logic deny_o,
	output acw_prot_pkg::deny_rec_t deny_rec_o,
	output acw_prot_pkg::gate_state_e state_o
);
	import acw_bus_pkg::*;
	import acw_prot_pkg::*;

	gate_state_e state_q;
	gate_state_e state_d;
	deny_rec_t rec_q;
	logic [7:0] src_q;
	logic deny_q;
	logic denied;
	tl_d2h_t err_rsp;

	// refused in the same cycle it shows up
	assign denied = (state_q == IDLE) && host_req_i.a_valid && !allow_i;

	// error reply built from the captured request
	always_comb begin
		err_rsp = '0;
		err_rsp.d_valid = 1'b1;
		err_rsp.d_opcode = (rec_q.opcode == Get) ? AccessAckData : AccessAck;
		err_rsp.d_source = src_q;
		err_rsp.d_error = 1'b1;
	end

	always_comb begin
		state_d = state_q;
		// default is straight pass-through in both directions
		dev_req_o = host_req_i;
		host_rsp_o = dev_rsp_i;
		case (state_q)
			IDLE: begin
				dev_req_o.a_valid = host_req_i.a_valid && allow_i;
				host_rsp_o.a_ready = dev_rsp_i.a_ready && allow_i;
				if (denied)
					state_d = BLOCK_START;
			end
			BLOCK_START: begin
				dev_req_o.a_valid = 1'b0;
				dev_req_o.d_ready = 1'b0;
				host_rsp_o = err_rsp;
				if (go_idle_i)
					state_d = host_req_i.d_ready ? IDLE : BLOCK_IDLE;
				else if (host_req_i.d_ready)
					state_d = BLOCK_ERR;
			end
			BLOCK_IDLE: begin
				// go-idle already seen, just finish the error reply
				dev_req_o.a_valid = 1'b0;
				dev_req_o.d_ready = 1'b0;
				host_rsp_o = err_rsp;
				if (host_req_i.d_ready)
					state_d = IDLE;
			end
			default: begin
				// device replies still drain, new host requests stall
				dev_req_o.a_valid = 1'b0;
				host_rsp_o.a_ready = 1'b0;
				if (go_idle_i)
					state_d = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk, negedge rst) begin
		if (!rst) begin
			state_q <= IDLE;
			rec_q <= '0;
			src_q <= '0;
			deny_q <= 1'b0;
		end else begin
			state_q <= state_d;
			deny_q <= denied;
			// record is kept until the next denial
			if (denied) begin
				rec_q.addr <= host_req_i.a_address;
				rec_q.opcode <= host_req_i.a_opcode;
				src_q <= host_req_i.a_source;
			end
		end
	end

	assign deny_o = deny_q;
	assign deny_rec_o = rec_q;
	assign state_o = state_q;

endmodule

/* design/acw_csr_port.sv */
// CPU register port, decodes Put/Get requests, holds one response and the interrupt registers
`include "acw_params.svh"

module acw_csr_port (
	input  logic clk,
	input  logic rst,
	input  acw_bus_pkg::tl_h2d_t cpu_req_i,
	output acw_bus_pkg::tl_d2h_t cpu_rsp_o,
	input  logic deny_i,
	input  acw_prot_pkg::deny_rec_t deny_rec_i,
	input  acw_prot_pkg::gate_state_e state_i,
	output logic go_idle_o,
	output logic reg_wr_en_o,
	output logic [3:0] reg_wr_idx_o,
	output logic [31:0] reg_wr_data_o,
	output logic [3:0] reg_rd_idx_o,
	input  logic [31:0] reg_rd_data_i,
	output logic irq_o
);
	import acw_bus_pkg::*;

	// response slot, d_valid doubles as the pending flag
	tl_d2h_t rsp_q;
	logic accept;
	logic [7:0] ofs;
	logic is_put, is_get, in_map, is_rd, is_wr, ok, wr_ok;
	logic [31:0] rdata;
	logic intr_state_q, intr_en_q;

	assign accept = cpu_req_i.a_valid && !rsp_q.d_valid;
	assign ofs = cpu_req_i.a_address[9:2];
	assign is_put = (cpu_req_i.a_opcode == PutFullData) || (cpu_req_i.a_opcode == PutPartialData);
	assign is_get = cpu_req_i.a_opcode == Get;

	// map ends after the last region address word
	assign in_map = ofs < (`ACW_OFS_REGIONS + `ACW_NUM_CFG_WORDS + `ACW_NUM_REGIONS);
	assign is_rd = in_map && (ofs != `ACW_OFS_GO_IDLE) && (ofs != `ACW_OFS_INTR_TEST);
	assign is_wr = in_map && ((ofs == `ACW_OFS_GO_IDLE) || (ofs >= `ACW_OFS_INTR_STATE));
	// full word only, inside the base window
	assign ok = (cpu_req_i.a_size == 2'd2) && (&cpu_req_i.a_mask) &&
		(cpu_req_i.a_address[31:10] == `ACW_BASE_ADDR) &&
		((is_put && is_wr) || (is_get && is_rd));
	assign wr_ok = accept && ok && is_put;

	// region table side, index relative to first config word
	assign reg_rd_idx_o = 4'(ofs - `ACW_OFS_REGIONS);
	assign reg_wr_idx_o = reg_rd_idx_o;
	assign reg_wr_data_o = cpu_req_i.a_data;
	assign reg_wr_en_o = wr_ok && (ofs >= `ACW_OFS_REGIONS);
	assign go_idle_o = wr_ok && (ofs == `ACW_OFS_GO_IDLE);

	always_comb begin
		case (ofs)
			`ACW_OFS_DENIED_ADDR: rdata = deny_rec_i.addr;
			`ACW_OFS_DENIED_TYPE: rdata = {29'b0, deny_rec_i.opcode};
			`ACW_OFS_STATE: rdata = {30'b0, state_i};
			`ACW_OFS_INTR_STATE: rdata = {31'b0, intr_state_q};
			`ACW_OFS_INTR_ENABLE: rdata = {31'b0, intr_en_q};
			default: rdata = reg_rd_data_i;
		endcase
	end

	always_ff @(posedge clk, negedge rst) begin
		if (!rst) begin
			rsp_q <= '0;
		end else if (accept) begin
			rsp_q.d_valid <= 1'b1;
			// errors reply as AccessAckData with zero data
			rsp_q.d_opcode <= (is_get || !ok) ? AccessAckData : AccessAck;
			rsp_q.d_data <= (ok && is_get) ? rdata : '0;
			rsp_q.d_source <= cpu_req_i.a_source;
			rsp_q.d_error <= !ok;
		end else if (cpu_req_i.d_ready) begin
			rsp_q.d_valid <= 1'b0;
		end
	end

	// denial and test set the state, a state write clears it
	always_ff @(posedge clk, negedge rst) begin
		if (!rst) begin
			intr_state_q <= 1'b0;
			intr_en_q <= 1'b0;
		end else begin
			if (deny_i || (wr_ok && (ofs == `ACW_OFS_INTR_TEST) && cpu_req_i.a_data[0]))
				intr_state_q <= 1'b1;
			else if (wr_ok && (ofs == `ACW_OFS_INTR_STATE))
				intr_state_q <= 1'b0;
			if (wr_ok && (ofs == `ACW_OFS_INTR_ENABLE))
				intr_en_q <= cpu_req_i.a_data[0];
		end
	end

	always_comb begin
		cpu_rsp_o = rsp_q;
		cpu_rsp_o.a_ready = !rsp_q.d_valid;
	end

	assign irq_o = intr_state_q & intr_en_q;

endmodule

/* design/acw_top.sv */
// access-control wrapper top, places the register port, region table, checker and host gate
`include "acw_params.svh"

module acw_top (
	input  logic clk,
	input  logic rst,
	input  acw_bus_pkg::tl_h2d_t host_req_i,
	output acw_bus_pkg::tl_d2h_t host_rsp_o,
	output acw_bus_pkg::tl_h2d_t dev_req_o,
	input  acw_bus_pkg::tl_d2h_t dev_rsp_i,
	input  acw_bus_pkg::tl_h2d_t cpu_req_i,
	output acw_bus_pkg::tl_d2h_t cpu_rsp_o,
	output logic irq_o
);
	import acw_prot_pkg::*;

	cfg_word_u [`ACW_NUM_CFG_WORDS-1:0] cfg;
	logic [`ACW_NUM_REGIONS-1:0][29:0] region_addr;
	logic reg_wr_en;
	logic [3:0] reg_wr_idx;
	logic [31:0] reg_wr_data;
	logic [3:0] reg_rd_idx;
	logic [31:0] reg_rd_data;
	logic allow;
	logic go_idle;
	logic deny;
	deny_rec_t deny_rec;
	gate_state_e gate_state;

	acw_csr_port u_csr_port (
		.clk(clk), .rst(rst), .cpu_req_i(cpu_req_i), .cpu_rsp_o(cpu_rsp_o),
		.deny_i(deny), .deny_rec_i(deny_rec), .state_i(gate_state), .go_idle_o(go_idle),
		.reg_wr_en_o(reg_wr_en), .reg_wr_idx_o(reg_wr_idx), .reg_wr_data_o(reg_wr_data),
		.reg_rd_idx_o(reg_rd_idx), .reg_rd_data_i(reg_rd_data), .irq_o(irq_o)
	);

	acw_region_regs u_region_regs (
		.clk(clk), .rst(rst), .wr_en_i(reg_wr_en), .wr_idx_i(reg_wr_idx),
		.wr_data_i(reg_wr_data), .rd_idx_i(reg_rd_idx), .rd_data_o(reg_rd_data),
		.cfg_o(cfg), .addr_o(region_addr)
	);

	// checker looks at the host request as it arrives
	acw_region_check u_region_check (
		.cfg_i(cfg), .addr_i(region_addr), .req_addr_i(host_req_i.a_address),
		.req_opcode_i(host_req_i.a_opcode), .allow_o(allow)
	);

	acw_host_gate u_host_gate (
		.clk(clk), .rst(rst), .host_req_i(host_req_i), .host_rsp_o(host_rsp_o),
		.dev_req_o(dev_req_o), .dev_rsp_i(dev_rsp_i), .allow_i(allow), .go_idle_i(go_idle),
		.deny_o(deny), .deny_rec_o(deny_rec), .state_o(gate_state)
	);

endmodule

/* tb/acw_tb_table.svh */
// entry table and random data source for the wrapper testbench, included inside the testbench module
`ifndef ACW_TB_TABLE_SVH
`define ACW_TB_TABLE_SVH

	// device replies carry the request address XOR this constant
	localparam logic [31:0] dev_xor = 32'h5a5a_0000;

	typedef enum logic [1:0] {
		K_WRITE,
		K_READ,
		K_HOST,
		K_STALL
	} kind_e;

	// one stimulus step with the response it should produce
	typedef struct packed {
		kind_e       kind;
		logic [31:0] addr;
		logic [31:0] data;
		logic [2:0]  opcode;
		logic [1:0]  size;
		logic [3:0]  mask;
		logic [31:0] exp_data;
		logic        exp_err;
		logic        exp_dev;
		logic        exp_irq;
	} entry_t;

	entry_t steps[$];

	// 32-bit xorshift step
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic queue_write(input logic [31:0] addr, input logic [31:0] data, input logic irq);
		steps.push_back('{K_WRITE, addr, data, 3'h0, 2'd2, 4'hf, 32'h0, 1'b0, 1'b0, irq});
	endtask

	task automatic expect_read(input logic [31:0] addr, input logic [31:0] exp, input logic irq);
		steps.push_back('{K_READ, addr, 32'h0, 3'h4, 2'd2, 4'hf, exp, 1'b0, 1'b0, irq});
	endtask

	// register-port request that must come back as an error
	task automatic bad_request(input logic [31:0] addr, input logic [2:0] opcode,
		input logic [1:0] size, input logic [3:0] mask, input logic [31:0] data, input logic irq);
		kind_e kind;
		kind = (opcode == 3'h4) ? K_READ : K_WRITE;
		steps.push_back('{kind, addr, data, opcode, size, mask, 32'h0, 1'b1, 1'b0, irq});
	endtask

	// allowed requests get the device reply, refused ones an error with zero data
	task automatic host_access(input logic [2:0] opcode, input logic [31:0] addr,
		input logic [31:0] data, input logic allow, input logic irq);
		logic [31:0] exp;
		exp = allow ? (addr ^ dev_xor) : 32'h0;
		steps.push_back('{K_HOST, addr, data, opcode, 2'd2, 4'hf, exp, !allow, allow, irq});
	endtask

	task automatic stall_check(input logic [31:0] addr, input logic irq);
		steps.push_back('{K_STALL, addr, 32'h0, 3'h4, 2'd2, 4'hf, 32'h0, 1'b0, 1'b0, irq});
	endtask

	task automatic build_table();
		logic [31:0] rnd [6];
		logic [31:0] seed;
		seed = 32'd2;
		for (int i = 0; i < 6; i++) begin
			seed = xorshift(seed);
			rnd[i] = seed;
		end
		// address words only keep bits 29:0
		rnd[2][31:30] = 2'b00;
		rnd[3][31:30] = 2'b00;
		// random region words, config 0/1 and address words 0 and 7
		queue_write(32'h1c, rnd[0], 1'b0);
		queue_write(32'h20, rnd[1], 1'b0);
		queue_write(32'h24, rnd[2], 1'b0);
		queue_write(32'h40, rnd[3], 1'b0);
		expect_read(32'h1c, rnd[0], 1'b0);
		expect_read(32'h20, rnd[1], 1'b0);
		expect_read(32'h24, rnd[2], 1'b0);
		expect_read(32'h40, rnd[3], 1'b0);
		// offset 17, Get of go-idle, size 1, partial mask, wrong base
		bad_request(32'h44, 3'h0, 2'd2, 4'hf, ~rnd[0], 1'b0);
		bad_request(32'h00, 3'h4, 2'd2, 4'hf, 32'h0, 1'b0);
		bad_request(32'h1c, 3'h0, 2'd1, 4'hf, ~rnd[0], 1'b0);
		bad_request(32'h1c, 3'h0, 2'd2, 4'h3, ~rnd[0], 1'b0);
		bad_request(32'h41c, 3'h0, 2'd2, 4'hf, ~rnd[0], 1'b0);
		expect_read(32'h1c, rnd[0], 1'b0);
		// region 0 TOR rw below 0x1000, region 1 TOR read-only below 0x2000
		queue_write(32'h1c, 32'h0000_090b, 1'b0);
		queue_write(32'h20, 32'h0, 1'b0);
		queue_write(32'h24, 32'h400, 1'b0);
		queue_write(32'h28, 32'h800, 1'b0);
		queue_write(32'h14, 32'h1, 1'b0);
		host_access(3'h0, 32'h100, rnd[4], 1'b1, 1'b0);
		host_access(3'h4, 32'h104, 32'h0, 1'b1, 1'b0);
		// above every region
		host_access(3'h4, 32'h3000, 32'h0, 1'b0, 1'b1);
		expect_read(32'h04, 32'h3000, 1'b1);
		expect_read(32'h08, 32'h4, 1'b1);
		expect_read(32'h0c, 32'h3, 1'b1);
		stall_check(32'h200, 1'b1);
		queue_write(32'h00, 32'h1, 1'b1);
		expect_read(32'h0c, 32'h0, 1'b1);
		host_access(3'h4, 32'h200, 32'h0, 1'b1, 1'b1);
		queue_write(32'h10, 32'h1, 1'b0);
		// Put into the read-only region
		host_access(3'h0, 32'h1800, rnd[5], 1'b0, 1'b1);
		expect_read(32'h04, 32'h1800, 1'b1);
		expect_read(32'h08, 32'h0, 1'b1);
		queue_write(32'h00, 32'h1, 1'b1);
		queue_write(32'h14, 32'h0, 1'b0);
		queue_write(32'h10, 32'h1, 1'b0);
		// opcode 2 is never allowed, irq masked by the enable
		host_access(3'h2, 32'h300, 32'h0, 1'b0, 1'b0);
		expect_read(32'h10, 32'h1, 1'b0);
		expect_read(32'h08, 32'h2, 1'b0);
		queue_write(32'h00, 32'h1, 1'b0);
		queue_write(32'h14, 32'h1, 1'b1);
		queue_write(32'h10, 32'h1, 1'b0);
		queue_write(32'h18, 32'h1, 1'b1);
		expect_read(32'h10, 32'h1, 1'b1);
	endtask

`endif

/* tb/acw_tb.sv */
// testbench top for the access-control wrapper, runs the entry table through the DUT ports
module acw_tb;
	import acw_bus_pkg::*;

	`include "acw_tb_table.svh"

	localparam int reset_cycles = 16;

	logic clk;
	logic rst;
	tl_h2d_t host_req;
	tl_d2h_t host_rsp;
	tl_h2d_t dev_req;
	tl_d2h_t dev_rsp;
	tl_h2d_t cpu_req;
	tl_d2h_t cpu_rsp;
	logic irq;
	// every A beat that reached the device
	tl_h2d_t dev_log[$];
	logic dev_a_fire;
	logic dev_d_fire;
	int step_errs;
	int passed;
	int failed;
	int cycles;
	int limit;

	acw_top u_dut (
		.clk(clk), .rst(rst), .host_req_i(host_req), .host_rsp_o(host_rsp),
		.dev_req_o(dev_req), .dev_rsp_i(dev_rsp), .cpu_req_i(cpu_req), .cpu_rsp_o(cpu_rsp),
		.irq_o(irq)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// device side beats seen at the rising edge
	always @(posedge clk) begin
		dev_a_fire = dev_req.a_valid && dev_rsp.a_ready;
		dev_d_fire = dev_rsp.d_valid && dev_req.d_ready;
		if (dev_a_fire)
			dev_log.push_back(dev_req);
	end

	// device takes every A beat and answers one cycle later
	initial begin
		dev_rsp = '0;
		dev_rsp.a_ready = 1'b1;
		forever begin
			@(negedge clk);
			if (dev_d_fire)
				dev_rsp.d_valid = 1'b0;
			if (dev_a_fire) begin
				dev_rsp.d_valid = 1'b1;
				dev_rsp.d_opcode = (dev_log[$].a_opcode == Get) ? AccessAckData : AccessAck;
				dev_rsp.d_data = dev_log[$].a_address ^ dev_xor;
				dev_rsp.d_source = dev_log[$].a_source;
			end
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else begin
			$display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
			step_errs++;
		end
	endtask

	task automatic drive_host(input entry_t e, input int idx);
		host_req.a_valid = 1'b1;
		host_req.a_opcode = tl_opcode_a_e'(e.opcode);
		host_req.a_address = e.addr;
		host_req.a_data = e.data;
		host_req.a_source = 8'(idx);
		host_req.a_size = e.size;
		host_req.a_mask = e.mask;
	endtask

	// handshakes are sampled mid-cycle, a short delay after the falling edge
	task automatic run_cpu(input entry_t e, input int idx);
		tl_d2h_t rsp;
		tl_opcode_d_e exp_op;
		cpu_req.a_valid = 1'b1;
		cpu_req.a_opcode = tl_opcode_a_e'(e.opcode);
		cpu_req.a_address = e.addr;
		cpu_req.a_data = e.data;
		cpu_req.a_source = 8'(idx);
		cpu_req.a_size = e.size;
		cpu_req.a_mask = e.mask;
		#1;
		while (!cpu_rsp.a_ready) begin
			@(negedge clk);
			#1;
		end
		// accepted at the rising edge in between
		@(negedge clk);
		cpu_req.a_valid = 1'b0;
		#1;
		while (!cpu_rsp.d_valid) begin
			@(negedge clk);
			#1;
		end
		rsp = cpu_rsp;
		@(negedge clk);
		// errors and reads answer with data, good writes with a plain ack
		exp_op = (e.exp_err || e.kind == K_READ) ? AccessAckData : AccessAck;
		check_value("cpu d_data", rsp.d_data, e.exp_data);
		check_value("cpu d_error", 32'(rsp.d_error), 32'(e.exp_err));
		check_value("cpu d_source", 32'(rsp.d_source), 32'(8'(idx)));
		check_value("cpu d_opcode", 32'(rsp.d_opcode), 32'(exp_op));
	endtask

	task automatic run_host(input entry_t e, input int idx);
		tl_d2h_t rsp;
		tl_h2d_t sent;
		tl_opcode_d_e exp_op;
		int seen;
		seen = dev_log.size();
		drive_host(e, idx);
		sent = host_req;
		#1;
		// a refused request is answered without being accepted
		while (!host_rsp.d_valid) begin
			if (host_rsp.a_ready && host_req.a_valid) begin
				@(negedge clk);
				host_req.a_valid = 1'b0;
			end else begin
				@(negedge clk);
			end
			#1;
		end
		rsp = host_rsp;
		@(negedge clk);
		host_req.a_valid = 1'b0;
		exp_op = (e.opcode == 3'h4) ? AccessAckData : AccessAck;
		check_value("host d_data", rsp.d_data, e.exp_data);
		check_value("host d_error", 32'(rsp.d_error), 32'(e.exp_err));
		check_value("host d_source", 32'(rsp.d_source), 32'(8'(idx)));
		check_value("host d_opcode", 32'(rsp.d_opcode), 32'(exp_op));
		check_value("device beats", 32'(dev_log.size() - seen), 32'(e.exp_dev));
		if (e.exp_dev && dev_log.size() > seen) begin
			assert (dev_log[$] == sent)
			else begin
				$display("[ERROR] %0t dev_req_o: got %h, expected %h", $time, dev_log[$], sent);
				step_errs++;
			end
		end
	endtask

	// blocked gate must neither accept nor answer for a while
	task automatic run_stall(input entry_t e, input int idx);
		int seen;
		seen = dev_log.size();
		drive_host(e, idx);
		repeat (6) begin
			#1;
			assert (!host_rsp.a_ready && !host_rsp.d_valid)
			else begin
				$display("blocked host request was accepted or answered at %0t", $time);
				step_errs++;
			end
			@(negedge clk);
		end
		host_req.a_valid = 1'b0;
		check_value("device beats", 32'(dev_log.size() - seen), 32'h0);
	endtask

	initial begin
		rst = 1'b0;
		host_req = '0;
		host_req.d_ready = 1'b1;
		cpu_req = '0;
		cpu_req.d_ready = 1'b1;
		passed = 0;
		failed = 0;
		build_table();
		limit = 40 * steps.size() + reset_cycles;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
		foreach (steps[i]) begin
			step_errs = 0;
			case (steps[i].kind)
				K_WRITE, K_READ: run_cpu(steps[i], i);
				K_HOST: run_host(steps[i], i);
				default: run_stall(steps[i], i);
			endcase
			check_value("irq_o", 32'(irq), 32'(steps[i].exp_irq));
			if (step_errs == 0) begin
				passed++;
				$display("entry %0d addr %h ok", i, steps[i].addr);
			end else begin
				failed++;
				$display("entry %0d addr %h had %0d errors", i, steps[i].addr, step_errs);
			end
		end
		$display("entries: %0d passed, %0d failed", passed, failed);
		if (failed == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	// cycle budget from the table length
	initial begin
		cycles = 0;
		wait (limit > 0);
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: no response");
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+design
+incdir+tb
design/acw_bus_pkg.sv
design/acw_prot_pkg.sv
design/acw_region_regs.sv
design/acw_region_check.sv
design/acw_host_gate.sv
design/acw_csr_port.sv
design/acw_top.sv
tb/acw_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the wrapper testbench with Verilator, run it and look for the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module acw_tb -o acw_sim

./obj_dir/acw_sim | tee sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
